/* mmu_consts.svh */
`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

// address and page number widths
`define MMU_VA_WIDTH 32
`define MMU_PA_WIDTH 34
`define MMU_VPN_WIDTH 20
`define MMU_PPN_WIDTH 22

// translation cache depth
`define MMU_TLB_ENTRIES 4

// privilege encodings, same as mstatus.mpp
`define MMU_PRV_U 2'd0
`define MMU_PRV_S 2'd1
`define MMU_PRV_M 2'd3

// satp.mode value that turns on sv32
`define MMU_SATP_SV32 1'b1

`endif

/* priv_pkg.sv */
`default_nettype none

package priv_pkg;

    // privilege mode as carried on prv and mpp
    typedef logic [1:0] priv_t;

    // kind of memory access behind a request
    typedef enum logic [1:0] {
        acc_read  = 2'd0,
        acc_write = 2'd1,
        acc_exec  = 2'd2
    } access_t;

endpackage

`default_nettype wire

/* sv32_pkg.sv */
`default_nettype none

package sv32_pkg;

    // leaf view, ppn split for superpage address forming
    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0]  ppn0;
        logic [1:0]  rsw;
        logic        d;
        logic        a;
        logic        g;
        logic        u;
        logic        x;
        logic        w;
        logic        r;
        logic        v;
    } pte_fields_t;

    // pointer view, whole ppn is the next table base
    typedef struct packed {
        logic [21:0] ppn;
        logic [1:0]  rsw;
        logic        d;
        logic        a;
        logic        g;
        logic        u;
        logic        x;
        logic        w;
        logic        r;
        logic        v;
    } pte_ptr_t;

    typedef union packed {
        pte_fields_t fields;
        pte_ptr_t    ptr;
        logic [31:0] raw;
    } pte_u;

    typedef struct packed {
        logic access_fault;
        logic page_fault;
    } mmu_status_t;

endpackage

`default_nettype wire

/* tlb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_consts.svh"

module tlb #(
    parameter int entries = `MMU_TLB_ENTRIES
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic [`MMU_VPN_WIDTH-1:0] lookup_vpn,
    output logic                      hit,
    output sv32_pkg::pte_u            hit_pte,
    output logic                      hit_spage,
    input  logic                      fill_en,
    input  logic [`MMU_VPN_WIDTH-1:0] fill_vpn,
    input  sv32_pkg::pte_u            fill_pte,
    input  logic                      fill_spage,
    input  logic                      tlb_flush_req,
    input  logic                      tlb_flush_all,
    input  logic [`MMU_VA_WIDTH-1:0]  tlb_flush_va
);
    import sv32_pkg::*;

    localparam int idx_w = (entries > 1) ? $clog2(entries) : 1;

    logic [entries-1:0]        valid_q;
    logic [entries-1:0]        spage_q;
    logic [`MMU_VPN_WIDTH-1:0] vpn_q [entries];
    pte_u                      pte_q [entries];
    logic [idx_w-1:0]          victim_q;
    logic [entries-1:0]        lookup_match;
    logic [entries-1:0]        flush_match;
    logic [`MMU_VPN_WIDTH-1:0] flush_vpn;

    // a superpage entry ignores vpn0
    function automatic logic vpn_match(input logic [`MMU_VPN_WIDTH-1:0] entry_vpn,
                                       input logic spage,
                                       input logic [`MMU_VPN_WIDTH-1:0] vpn);
        return entry_vpn[19:10] == vpn[19:10] && (spage || entry_vpn[9:0] == vpn[9:0]);
    endfunction

    assign flush_vpn = tlb_flush_va[`MMU_VA_WIDTH-1 -: `MMU_VPN_WIDTH];

    for (genvar i = 0; i < entries; i++) begin : g_match
        assign lookup_match[i] = valid_q[i] && vpn_match(vpn_q[i], spage_q[i], lookup_vpn);
        assign flush_match[i]  = valid_q[i] && vpn_match(vpn_q[i], spage_q[i], flush_vpn);
    end

    always_comb begin
        hit       = 1'b0;
        hit_pte   = '0;
        hit_spage = 1'b0;
        for (int i = entries - 1; i >= 0; i--) begin
            if (lookup_match[i]) begin
                hit       = 1'b1;
                hit_pte   = pte_q[i];
                hit_spage = spage_q[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q  <= '0;
            victim_q <= '0;
        end else begin
            if (tlb_flush_req) begin
                valid_q <= tlb_flush_all ? '0 : (valid_q & ~flush_match);
            end
            // round robin replacement
            if (fill_en) begin
                valid_q[victim_q] <= 1'b1;
                victim_q <= (victim_q == idx_w'(entries - 1)) ? '0 : victim_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            vpn_q[victim_q]   <= fill_vpn;
            pte_q[victim_q]   <= fill_pte;
            spage_q[victim_q] <= fill_spage;
        end
    end

endmodule

`default_nettype wire

/* ptw.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_consts.svh"

module ptw (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      walk_start,
    input  logic [`MMU_PPN_WIDTH-1:0] walk_root_ppn,
    input  logic [`MMU_VPN_WIDTH-1:0] walk_vpn,
    output logic                      walk_done,
    output sv32_pkg::pte_u            walk_pte,
    output logic                      walk_level,
    output logic                      walk_pf,
    output logic                      walk_bus_err,
    output logic                      wb_cyc,
    output logic                      wb_stb,
    output logic                      wb_we,
    output logic [`MMU_PA_WIDTH-1:0]  wb_adr,
    output logic [3:0]                wb_sel,
    input  logic [31:0]               wb_dat_i,
    input  logic                      wb_ack,
    input  logic                      wb_err
);
    import sv32_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_wait
    } state_t;

    state_t                    state_q;
    logic                      req_q;
    logic                      level_q;
    logic [`MMU_PPN_WIDTH-1:0] base_q;
    logic [9:0]                vpn_part;
    pte_u                      rd_pte;
    logic                      rd_leaf;
    logic                      rd_fault;
    logic                      bus_end;
    logic                      descend;

    assign rd_pte.raw = wb_dat_i;
    assign rd_leaf    = rd_pte.fields.v && (rd_pte.fields.r || rd_pte.fields.x);

    // invalid, w without r, pointer at level 0, misaligned superpage
    assign rd_fault = !rd_pte.fields.v
                   || (rd_pte.fields.w && !rd_pte.fields.r)
                   || (!rd_leaf && !level_q)
                   || (rd_leaf && level_q && rd_pte.fields.ppn0 != '0);

    assign bus_end  = state_q == st_wait && (wb_ack || wb_err);
    assign descend  = bus_end && !wb_err && !rd_leaf && !rd_fault;
    assign vpn_part = level_q ? walk_vpn[19:10] : walk_vpn[9:0];

    // read only master, word wide
    assign wb_cyc = req_q;
    assign wb_stb = req_q;
    assign wb_we  = 1'b0;
    assign wb_sel = 4'hf;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q   <= st_idle;
            req_q     <= 1'b0;
            level_q   <= 1'b1;
            walk_done <= 1'b0;
        end else begin
            walk_done <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (walk_start) begin
                        level_q <= 1'b1;
                        state_q <= st_issue;
                    end
                end
                st_issue: begin
                    req_q   <= 1'b1;
                    state_q <= st_wait;
                end
                st_wait: begin
                    if (bus_end) begin
                        req_q <= 1'b0;
                        if (descend) begin
                            level_q <= 1'b0;
                            state_q <= st_issue;
                        end else begin
                            walk_done <= 1'b1;
                            state_q   <= st_idle;
                        end
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == st_idle && walk_start) begin
            base_q <= walk_root_ppn;
        end else if (descend) begin
            base_q <= rd_pte.ptr.ppn;
        end
        // table base times 4096 plus index times 4
        if (state_q == st_issue) begin
            wb_adr <= {base_q, vpn_part, 2'b00};
        end
        if (bus_end) begin
            walk_pte     <= rd_pte;
            walk_level   <= level_q;
            walk_pf      <= !wb_err && rd_fault;
            walk_bus_err <= wb_err;
        end
    end

endmodule

`default_nettype wire

/* mmu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_consts.svh"

module mmu (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      va_valid,
    input  logic [`MMU_VA_WIDTH-1:0]  va,
    input  priv_pkg::access_t         access,
    input  priv_pkg::priv_t           prv,
    input  logic                      mprv,
    input  priv_pkg::priv_t           mpp,
    input  logic                      sum,
    input  logic                      satp_mode,
    input  logic [`MMU_PPN_WIDTH-1:0] satp_ppn,
    output logic                      busy,
    output logic                      pa_valid,
    output logic [`MMU_PA_WIDTH-1:0]  pa,
    output sv32_pkg::mmu_status_t     status,
    output logic [`MMU_VPN_WIDTH-1:0] lookup_vpn,
    input  logic                      hit,
    input  sv32_pkg::pte_u            hit_pte,
    input  logic                      hit_spage,
    output logic                      fill_en,
    output logic [`MMU_VPN_WIDTH-1:0] fill_vpn,
    output sv32_pkg::pte_u            fill_pte,
    output logic                      fill_spage,
    output logic                      walk_start,
    output logic [`MMU_PPN_WIDTH-1:0] walk_root_ppn,
    output logic [`MMU_VPN_WIDTH-1:0] walk_vpn,
    input  logic                      walk_done,
    input  sv32_pkg::pte_u            walk_pte,
    input  logic                      walk_level,
    input  logic                      walk_pf,
    input  logic                      walk_bus_err
);
    import priv_pkg::*;
    import sv32_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_check,
        st_walk
    } state_t;

    state_t                    state_q;
    logic                      accept;
    logic                      translate;
    priv_t                     eff_prv;
    logic [`MMU_VA_WIDTH-1:0]  va_q;
    access_t                   access_q;
    priv_t                     prv_q;
    logic                      sum_q;
    logic [`MMU_PPN_WIDTH-1:0] root_q;
    logic                      use_walk;
    logic                      result_en;
    pte_u                      leaf_pte;
    logic                      leaf_spage;
    logic                      perm_fault;
    logic [`MMU_PA_WIDTH-1:0]  leaf_pa;
    mmu_status_t               leaf_status;

    // mprv moves loads and stores to mpp, fetches keep prv
    assign eff_prv   = (mprv && access != acc_exec) ? mpp : prv;
    assign translate = satp_mode == `MMU_SATP_SV32 && eff_prv != `MMU_PRV_M;
    assign accept    = va_valid && state_q == st_idle;
    assign busy      = state_q != st_idle;

    assign lookup_vpn    = va_q[`MMU_VA_WIDTH-1 -: `MMU_VPN_WIDTH];
    assign walk_vpn      = va_q[`MMU_VA_WIDTH-1 -: `MMU_VPN_WIDTH];
    assign walk_root_ppn = root_q;

    // one leaf path for tlb hits and walk results
    assign use_walk   = state_q == st_walk;
    assign leaf_pte   = use_walk ? walk_pte : hit_pte;
    assign leaf_spage = use_walk ? walk_level : hit_spage;
    assign result_en  = (state_q == st_check && hit) || (use_walk && walk_done);

    assign perm_fault = !leaf_pte.fields.a
                     || (access_q == acc_read && !leaf_pte.fields.r)
                     || (access_q == acc_write && (!leaf_pte.fields.w || !leaf_pte.fields.d))
                     || (access_q == acc_exec && !leaf_pte.fields.x)
                     || (prv_q == `MMU_PRV_U && !leaf_pte.fields.u)
                     || (prv_q == `MMU_PRV_S && leaf_pte.fields.u
                         && (!sum_q || access_q == acc_exec));

    // superpage takes vpn0 in place of ppn0
    assign leaf_pa = {leaf_pte.fields.ppn1,
                      leaf_spage ? va_q[21:12] : leaf_pte.fields.ppn0,
                      va_q[11:0]};

    assign leaf_status.access_fault = use_walk && walk_bus_err;
    assign leaf_status.page_fault   = !(use_walk && walk_bus_err)
                                   && ((use_walk && walk_pf) || perm_fault);

    assign fill_en    = use_walk && walk_done && !walk_bus_err && !walk_pf && !perm_fault;
    assign fill_vpn   = va_q[`MMU_VA_WIDTH-1 -: `MMU_VPN_WIDTH];
    assign fill_pte   = walk_pte;
    assign fill_spage = walk_level;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q    <= st_idle;
            pa_valid   <= 1'b0;
            walk_start <= 1'b0;
        end else begin
            pa_valid   <= (accept && !translate) || result_en;
            walk_start <= state_q == st_check && !hit;
            case (state_q)
                st_idle: begin
                    if (accept && translate) begin
                        state_q <= st_check;
                    end
                end
                st_check: state_q <= hit ? st_idle : st_walk;
                st_walk: begin
                    if (walk_done) begin
                        state_q <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            va_q     <= va;
            access_q <= access;
            prv_q    <= eff_prv;
            sum_q    <= sum;
            root_q   <= satp_ppn;
        end
        // bare or machine mode passes the address through
        if (accept && !translate) begin
            pa     <= {{(`MMU_PA_WIDTH - `MMU_VA_WIDTH){1'b0}}, va};
            status <= '0;
        end else if (result_en) begin
            pa     <= leaf_pa;
            status <= leaf_status;
        end
    end

endmodule

`default_nettype wire

/* mmu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_consts.svh"

module mmu_top (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      va_valid,
    input  logic [`MMU_VA_WIDTH-1:0]  va,
    input  priv_pkg::access_t         access,
    input  priv_pkg::priv_t           prv,
    input  logic                      mprv,
    input  priv_pkg::priv_t           mpp,
    input  logic                      sum,
    input  logic                      satp_mode,
    input  logic [`MMU_PPN_WIDTH-1:0] satp_ppn,
    output logic                      busy,
    output logic                      pa_valid,
    output logic [`MMU_PA_WIDTH-1:0]  pa,
    output sv32_pkg::mmu_status_t     status,
    input  logic                      tlb_flush_req,
    input  logic                      tlb_flush_all,
    input  logic [`MMU_VA_WIDTH-1:0]  tlb_flush_va,
    output logic                      wb_cyc,
    output logic                      wb_stb,
    output logic                      wb_we,
    output logic [`MMU_PA_WIDTH-1:0]  wb_adr,
    output logic [3:0]                wb_sel,
    input  logic [31:0]               wb_dat_i,
    input  logic                      wb_ack,
    input  logic                      wb_err
);
    import sv32_pkg::*;

    // mmu to tlb
    logic [`MMU_VPN_WIDTH-1:0] lookup_vpn;
    logic                      hit;
    pte_u                      hit_pte;
    logic                      hit_spage;
    logic                      fill_en;
    logic [`MMU_VPN_WIDTH-1:0] fill_vpn;
    pte_u                      fill_pte;
    logic                      fill_spage;

    // mmu to ptw
    logic                      walk_start;
    logic [`MMU_PPN_WIDTH-1:0] walk_root_ppn;
    logic [`MMU_VPN_WIDTH-1:0] walk_vpn;
    logic                      walk_done;
    pte_u                      walk_pte;
    logic                      walk_level;
    logic                      walk_pf;
    logic                      walk_bus_err;

    mmu u_mmu (.*);

    tlb #(
        .entries(`MMU_TLB_ENTRIES)
    ) u_tlb (.*);

    ptw u_ptw (.*);

endmodule

`default_nettype wire

/* tb_pt_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pt_memory #(
    parameter logic [33:0] err_adr   = 34'h0,
    parameter integer      seed_init = 1
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [33:0] wb_adr,
    input  logic [3:0]  wb_sel,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack,
    output logic        wb_err
);
    // root table at 0x10000, level 0 table at 0x11000
    logic [31:0] mem [0:2047];
    logic [1:0]  wait_cnt;
    integer      seed = seed_init;
    logic        in_range;

    initial begin
        for (int i = 0; i < 2048; i++) begin
            mem[i] = 32'h0;
        end
        mem[1] = {22'h11, 10'h001};
        mem[2] = {12'h5, 10'h0, 10'h0cf};
        mem[3] = {12'h6, 10'h1, 10'h0cf};
        mem[4] = {22'h33, 10'h0c5};
        mem[5] = {22'h34, 10'h0cf};
        mem[6] = {12'h7, 10'h0, 10'h0df};
        for (int i = 0; i < 16; i++) begin
            mem[1024 + i] = {22'h20000 + 22'(i), 10'h0cf};
        end
        mem[1025] = {22'h20001, 10'h043};
        mem[1026] = {22'h20002, 10'h047};
        mem[1027] = {22'h20003, 10'h08f};
        mem[1028] = {22'h20004, 10'h049};
        mem[1029] = {22'h20005, 10'h0df};
        mem[1030] = {22'h0, 10'h001};
        mem[1031] = {22'h3fff10, 10'h0cf};
    end

    assign in_range = wb_adr >= 34'h10000 && wb_adr < 34'h12000;

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wb_ack   <= 1'b0;
            wb_err   <= 1'b0;
            wb_dat_o <= 32'h0;
            wait_cnt <= 2'd0;
        end else begin
            wb_ack <= 1'b0;
            wb_err <= 1'b0;
            if (wb_cyc && wb_stb && !wb_we && wb_sel == 4'hf && !wb_ack && !wb_err) begin
                if (wait_cnt == 2'd0) begin
                    if (wb_adr == err_adr) begin
                        wb_err <= 1'b1;
                    end else begin
                        wb_ack   <= 1'b1;
                        wb_dat_o <= in_range ? mem[wb_adr[12:2]] : 32'h0;
                    end
                    wait_cnt <= 2'($random(seed));
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb_mmu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_consts.svh"

module tb_mmu;
    import priv_pkg::*;

    localparam integer      seed_init   = 32'hdfce_cb80;
    localparam int          n_random    = 40;
    localparam int          n_directed  = 30;
    localparam int          total_req   = n_directed + n_random;
    localparam logic [21:0] pt_root_ppn = 22'h10;
    localparam logic [33:0] err_adr     = 34'h10014;

    logic                  clk = 1'b0;
    logic                  rstn;
    logic                  va_valid;
    logic [31:0]           va;
    access_t               access;
    priv_t                 prv;
    logic                  mprv;
    priv_t                 mpp;
    logic                  sum;
    logic                  satp_mode;
    logic [21:0]           satp_ppn;
    logic                  busy;
    logic                  pa_valid;
    logic [33:0]           pa;
    sv32_pkg::mmu_status_t status;
    logic                  tlb_flush_req;
    logic                  tlb_flush_all;
    logic [31:0]           tlb_flush_va;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [33:0]           wb_adr;
    logic [3:0]            wb_sel;
    logic [31:0]           wb_dat_i;
    logic                  wb_ack;
    logic                  wb_err;

    integer      seed = seed_init;
    logic [33:0] exp_pa;
    logic [1:0]  exp_st;
    logic        exp_tr;
    int          walk_chk;
    int          wb_count = 0;
    int          start_count;
    int          busy_cycles = 0;
    int          start_busy;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    string       test_name;
    event        resp_ev;

    mmu_top u_mmu_top (.*);

    tb_pt_memory #(
        .err_adr  (err_adr),
        .seed_init(seed_init)
    ) u_mem (
        .clk(clk), .rstn(rstn), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_sel(wb_sel), .wb_dat_o(wb_dat_i), .wb_ack(wb_ack),
        .wb_err(wb_err)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] pt_read(input logic [33:0] adr);
        if (adr >= 34'h10000 && adr < 34'h12000) begin
            return u_mem.mem[adr[12:2]];
        end
        return 32'h0;
    endfunction

    // pte flag bits v0 r1 w2 x3 u4 g5 a6 d7
    function automatic logic perm_denied(input logic [31:0] pte, input access_t acc,
                                         input priv_t eff, input logic s);
        return !pte[6]
            || (acc == acc_read && !pte[1])
            || (acc == acc_write && (!pte[2] || !pte[7]))
            || (acc == acc_exec && !pte[3])
            || (eff == `MMU_PRV_U && !pte[4])
            || (eff == `MMU_PRV_S && pte[4] && (!s || acc == acc_exec));
    endfunction

    function automatic void translate_ref(input logic [31:0] v, input access_t acc,
                                          input priv_t p, input logic mp, input priv_t mpp_i,
                                          input logic s, input logic mode,
                                          output logic [33:0] e_pa, output logic [1:0] e_st,
                                          output logic e_tr);
        priv_t       eff;
        logic [31:0] pte;
        logic [33:0] adr;
        logic        lvl1;
        eff  = (mp && acc != acc_exec) ? mpp_i : p;
        e_pa = {2'b00, v};
        e_st = 2'b00;
        e_tr = mode && eff != `MMU_PRV_M;
        if (!e_tr) begin
            return;
        end
        adr  = {pt_root_ppn, v[31:22], 2'b00};
        lvl1 = 1'b1;
        if (adr == err_adr) begin
            e_st = 2'b10;
            return;
        end
        pte = pt_read(adr);
        if (pte[0] && !pte[1] && !pte[3] && !pte[2]) begin
            adr  = {pte[31:10], v[21:12], 2'b00};
            lvl1 = 1'b0;
            if (adr == err_adr) begin
                e_st = 2'b10;
                return;
            end
            pte = pt_read(adr);
        end
        if (!pte[0] || (pte[2] && !pte[1]) || !(pte[1] || pte[3])
                || (lvl1 && pte[19:10] != 10'h0)) begin
            e_st = 2'b01;
            return;
        end
        if (perm_denied(pte, acc, eff, s)) begin
            e_st = 2'b01;
        end
        e_pa = lvl1 ? {pte[31:20], v[21:0]} : {pte[31:10], v[11:0]};
    endfunction

    always @(posedge clk) begin
        if (wb_cyc && (wb_ack || wb_err)) begin
            wb_count <= wb_count + 1;
        end
        if (busy) begin
            busy_cycles <= busy_cycles + 1;
        end
    end

    // comparator
    always @(posedge clk) begin : compare
        logic ok;
        int   walks;
        int   busy_n;
        if (rstn && pa_valid) begin
            ok     = 1'b1;
            walks  = wb_count - start_count;
            busy_n = busy_cycles - start_busy;
            if (status !== exp_st) begin
                $display("MISMATCH %s status got %h expected %h", test_name, status, exp_st);
                ok = 1'b0;
            end
            if (exp_st == 2'b00 && pa !== exp_pa) begin
                $display("MISMATCH %s pa got %h expected %h", test_name, pa, exp_pa);
                ok = 1'b0;
            end
            if (walk_chk == 1 && walks == 0) begin
                $display("%s: no page table read although the TLB should miss", test_name);
                ok = 1'b0;
            end
            if (walk_chk == 2 && walks != 0) begin
                $display("%s: page table read although none was expected", test_name);
                ok = 1'b0;
            end
            if (busy) begin
                $display("%s: busy still high in the cycle of pa_valid", test_name);
                ok = 1'b0;
            end
            if (!exp_tr && busy_n != 0) begin
                $display("%s: busy rose for an untranslated request", test_name);
                ok = 1'b0;
            end
            if (exp_tr && busy_n == 0) begin
                $display("%s: busy never rose for a translated request", test_name);
                ok = 1'b0;
            end
            if (exp_tr && walk_chk == 2 && busy_n != 1) begin
                $display("%s: TLB hit kept busy high for %0d cycles instead of one",
                         test_name, busy_n);
                ok = 1'b0;
            end
            if (ok) begin
                pass_cnt++;
            end else begin
                fail_cnt++;
            end
            $display("%s va %h: %s", test_name, va, ok ? "ok" : "failed");
            -> resp_ev;
        end
    end

    // chk 0 leaves walks unchecked, 1 expects a table read and 2 expects none
    task automatic run_request(input string name, input logic [31:0] v, input access_t acc,
                               input priv_t p, input logic mp, input priv_t mpp_i,
                               input logic s, input logic mode, input int chk);
        translate_ref(v, acc, p, mp, mpp_i, s, mode, exp_pa, exp_st, exp_tr);
        test_name   = name;
        walk_chk    = chk;
        start_count = wb_count;
        start_busy  = busy_cycles;
        @(posedge clk);
        va_valid  <= 1'b1;
        va        <= v;
        access    <= acc;
        prv       <= p;
        mprv      <= mp;
        mpp       <= mpp_i;
        sum       <= s;
        satp_mode <= mode;
        @(posedge clk);
        va_valid <= 1'b0;
        @(resp_ev);
    endtask

    task automatic flush_tlb(input logic all, input logic [31:0] v);
        @(posedge clk);
        tlb_flush_req <= 1'b1;
        tlb_flush_all <= all;
        tlb_flush_va  <= v;
        @(posedge clk);
        tlb_flush_req <= 1'b0;
    endtask

    initial begin : watchdog
        repeat (total_req * 200) @(posedge clk);
        $display("timeout: no response from the DUT in time");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] r;
        logic [31:0] vv;
        logic [1:0]  acc_sel;
        rstn          = 1'b0;
        va_valid      = 1'b0;
        va            = 32'h0;
        access        = acc_read;
        prv           = `MMU_PRV_S;
        mprv          = 1'b0;
        mpp           = `MMU_PRV_U;
        sum           = 1'b0;
        satp_mode     = 1'b0;
        satp_ppn      = pt_root_ppn;
        tlb_flush_req = 1'b0;
        tlb_flush_all = 1'b0;
        tlb_flush_va  = 32'h0;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        repeat (2) @(posedge clk);

        run_request("bare_m", 32'h0040_2abc, acc_read, `MMU_PRV_M, 0, `MMU_PRV_U, 0, 1, 2);
        run_request("bare_off", 32'hfedc_ba98, acc_write, `MMU_PRV_S, 0, `MMU_PRV_U, 0, 0, 2);
        run_request("mprv_m", 32'h0040_0010, acc_read, `MMU_PRV_S, 1, `MMU_PRV_M, 0, 1, 2);

        run_request("page_4k", 32'h0040_0123, acc_read, `MMU_PRV_S, 0, 0, 0, 1, 1);
        run_request("superpage", 32'h0081_2345, acc_write, `MMU_PRV_S, 0, 0, 0, 1, 1);
        run_request("high_ppn", 32'h0040_7fff, acc_exec, `MMU_PRV_S, 0, 0, 0, 1, 1);

        run_request("read_ok", 32'h0040_1004, acc_read, `MMU_PRV_S, 0, 0, 0, 1, 0);
        run_request("write_no_w", 32'h0040_1008, acc_write, `MMU_PRV_S, 0, 0, 0, 1, 0);
        run_request("write_no_d", 32'h0040_2008, acc_write, `MMU_PRV_S, 0, 0, 0, 1, 0);
        run_request("exec_no_x", 32'h0040_100c, acc_exec, `MMU_PRV_S, 0, 0, 0, 1, 0);
        run_request("exec_ok", 32'h0040_4010, acc_exec, `MMU_PRV_S, 0, 0, 0, 1, 0);
        run_request("no_a", 32'h0040_3000, acc_read, `MMU_PRV_S, 0, 0, 0, 1, 0);
        run_request("user_no_u", 32'h0040_0200, acc_read, `MMU_PRV_U, 0, 0, 0, 1, 0);
        run_request("sup_u_nosum", 32'h0040_5000, acc_read, `MMU_PRV_S, 0, 0, 0, 1, 0);
        run_request("sup_u_sum", 32'h0040_5004, acc_read, `MMU_PRV_S, 0, 0, 1, 1, 0);
        run_request("sup_u_sum_x", 32'h0040_5008, acc_exec, `MMU_PRV_S, 0, 0, 1, 1, 0);
        run_request("mprv_user", 32'h0180_0044, acc_read, `MMU_PRV_S, 1, `MMU_PRV_U, 0, 1, 0);
        run_request("invalid", 32'h0000_0000, acc_read, `MMU_PRV_S, 0, 0, 0, 1, 1);
        run_request("w_no_r", 32'h0100_0000, acc_read, `MMU_PRV_S, 0, 0, 0, 1, 1);
        run_request("misaligned", 32'h00c0_0000, acc_read, `MMU_PRV_S, 0, 0, 0, 1, 1);
        run_request("ptr_level0", 32'h0040_6000, acc_read, `MMU_PRV_S, 0, 0, 0, 1, 1);

        run_request("bus_error", 32'h0140_0000, acc_read, `MMU_PRV_S, 0, 0, 0, 1, 1);

        flush_tlb(1'b1, 32'h0);
        run_request("tlb_fill", 32'h0040_0123, acc_read, `MMU_PRV_S, 0, 0, 0, 1, 1);
        run_request("tlb_hit", 32'h0040_0456, acc_write, `MMU_PRV_S, 0, 0, 0, 1, 2);
        flush_tlb(1'b0, 32'h0040_0000);
        run_request("flush_va", 32'h0040_0123, acc_read, `MMU_PRV_S, 0, 0, 0, 1, 1);
        run_request("tlb_hit2", 32'h0040_0123, acc_read, `MMU_PRV_S, 0, 0, 0, 1, 2);
        run_request("spage_fill", 32'h0083_4567, acc_read, `MMU_PRV_S, 0, 0, 0, 1, 1);
        run_request("spage_hit", 32'h00ab_cdef, acc_read, `MMU_PRV_S, 0, 0, 0, 1, 2);
        flush_tlb(1'b1, 32'h0);
        run_request("flush_all", 32'h0040_0123, acc_read, `MMU_PRV_S, 0, 0, 0, 1, 1);
        run_request("spage_miss", 32'h00ab_cdef, acc_read, `MMU_PRV_S, 0, 0, 0, 1, 1);

        // pages 8 to 15 and the superpage overflow the four entries
        for (int n = 0; n < n_random; n++) begin
            r = $random(seed);
            if (r[12]) begin
                vv = {10'd2, r[22:13], r[11:0]};
            end else begin
                vv = {10'd1, 7'd1, r[15:13], r[11:0]};
            end
            acc_sel = (r[17:16] == 2'd3) ? 2'd0 : r[17:16];
            run_request("random", vv, access_t'(acc_sel), r[18] ? `MMU_PRV_U : `MMU_PRV_S,
                        0, 0, r[19], 1, 0);
        end

        $display("tests %0d passed %0d failed %0d", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
priv_pkg.sv
sv32_pkg.sv
tlb.sv
ptw.sv
mmu.sv
mmu_top.sv
tb_pt_memory.sv
tb_mmu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mmu
RTL_TOP   ?= mmu_top
FILELIST  ?= all.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD)/V$(TOP): $(shell grep -v '^+' $(FILELIST)) mmu_consts.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
